/* project.f */
hw/cachePkg.sv
hw/cacheWay.sv
hw/cacheLRU.sv
hw/wayHitSelect.sv
hw/cacheController.sv
hw/readCache.sv
dv/readCacheTb.sv

/* Makefile */
RTL = hw/cachePkg.sv hw/cacheWay.sv hw/cacheLRU.sv hw/wayHitSelect.sv \
      hw/cacheController.sv hw/readCache.sv

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f project.f --top-module readCacheTb -o readCacheTb

run: build
	./obj_dir/readCacheTb > run.log 2>&1 || true
	cat run.log
	@if grep -q "Errors found" run.log || ! grep -q "No errors" run.log; then \
	  echo "Simulation FAILED"; exit 1; \
	else \
	  echo "Simulation PASSED"; \
	fi

lint:
	verilator --lint-only -Wall --top-module readCache $(RTL)

clean:
	rm -rf obj_dir run.log

/* dv/readCacheTb.sv */
/*
  Random-stimulus testbench for the four-way read cache.
  Tasks are entered and left on a falling clock edge, where all inputs change.
  The reference model predicts hits and victims from its own copy of tags and tree bits.
  Memory words are a fixed function of the address, so any response can be checked.
*/
`timescale 1ns/1ps
`default_nettype none

module readCacheTb;
  import cachePkg::*;

  localparam int randomReqs = 200;
  localparam int totalReqs  = randomReqs + 60;
  localparam int cycleLimit = totalReqs * 40;

  logic clk;
  logic reset;
  logic reqValid;
  logic reqReady;
  cacheAddrT reqAddr;
  logic reqInvalidate;
  logic respValid;
  logic respReady;
  cacheDataT respData;
  logic memReqValid;
  logic memReqReady;
  cacheAddrT memReqAddr;
  logic memRespValid;
  cacheDataT memRespData;

  int unsigned mainSeed;
  int unsigned memSeed;
  int errorCount = 0;
  int checkCount = 0;
  int testCount = 0;
  int memReqCount = 0;
  int cycleCount;
  cacheAddrT lastMemAddr;

  // Reference model state, one entry per set and way
  cacheTagT modelTag [cacheSets][cacheWays];
  logic     modelValid [cacheSets][cacheWays];
  lruBitsT  modelTree [cacheSets];

  readCache readCache_i (
    .clk, .reset,
    .reqValid, .reqReady, .reqAddr, .reqInvalidate,
    .respValid, .respReady, .respData,
    .memReqValid, .memReqReady, .memReqAddr,
    .memRespValid, .memRespData
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic int unsigned lcgNext(inout int unsigned seed);
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed >> 16;
  endfunction

  // Mixing function of the whole address, used as memory contents
  function automatic cacheDataT memWord(input cacheAddrT a);
    return {a ^ 16'h5a3c, a * 16'd40503 + 16'd4097};
  endfunction

  task automatic modelClear();
    for (int s = 0; s < cacheSets; s++) begin
      modelTree[s] = '0;
      for (int w = 0; w < cacheWays; w++) begin
        modelValid[s][w] = 1'b0;
      end
    end
  endtask

  // Lowest invalid way first, otherwise follow root then pair node
  function automatic wayIndexT modelVictim(input cacheSetT s);
    for (int w = 0; w < cacheWays; w++) begin
      if (!modelValid[s][w]) return wayIndexT'(w);
    end
    if (modelTree[s][2]) return modelTree[s][1] ? 2'd3 : 2'd2;
    return modelTree[s][0] ? 2'd1 : 2'd0;
  endfunction

  // Point the root at the other pair and the pair node at the other way
  task automatic modelTouch(input cacheSetT s, input wayIndexT w);
    if (w == 2'd0 || w == 2'd1) begin
      modelTree[s][2] = 1'b1;
      modelTree[s][0] = (w == 2'd0);
    end else begin
      modelTree[s][2] = 1'b0;
      modelTree[s][1] = (w == 2'd2);
    end
  endtask

  task automatic modelAccess(input cacheAddrT addr, output logic hit);
    cacheSetT s;
    cacheTagT t;
    wayIndexT way;
    s = addr[setBits-1:0];
    t = addr[addrBits-1 -: tagBits];
    hit = 1'b0;
    way = '0;
    for (int w = 0; w < cacheWays; w++) begin
      if (modelValid[s][w] && modelTag[s][w] == t) begin
        hit = 1'b1;
        way = wayIndexT'(w);
      end
    end
    if (!hit) begin
      way = modelVictim(s);
      modelTag[s][way] = t;
      modelValid[s][way] = 1'b1;
    end
    modelTouch(s, way);
  endtask

  task automatic checkData(input cacheDataT actual, input cacheDataT expected, input string what);
    checkCount++;
    if (actual !== expected) begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
      errorCount++;
    end
  endtask

  task automatic checkAddr(input cacheAddrT actual, input cacheAddrT expected, input string what);
    checkCount++;
    if (actual !== expected) begin
      $display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
      errorCount++;
    end
  endtask

  task automatic checkMiss(input logic actual, input logic expected);
    checkCount++;
    if (actual !== expected) begin
      $display("Error at %0t: memory request seen %b, expected %b", $time, actual, expected);
      errorCount++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory responder with random stalls and delays
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int fillDelay;
    logic memHold;
    cacheAddrT heldAddr;
    cacheAddrT fillAddr;
    fillDelay = 0;
    memHold = 1'b0;
    heldAddr = '0;
    fillAddr = '0;
    memReqReady = 1'b0;
    memRespValid = 1'b0;
    memRespData = '0;
    forever begin
      @(negedge clk);
      memRespValid = 1'b0;
      if (fillDelay > 0) begin
        fillDelay--;
        if (fillDelay == 0) begin
          memRespValid = 1'b1;
          memRespData = memWord(fillAddr);
        end
      end
      // A stalled memory request must keep its address
      if (memReqValid && memHold) checkAddr(memReqAddr, heldAddr, "held memReqAddr");
      memReqReady = (lcgNext(memSeed) % 3) == 0;
      if (memReqValid && memReqReady) begin
        memReqCount++;
        lastMemAddr = memReqAddr;
        fillAddr = memReqAddr;
        fillDelay = int'(lcgNext(memSeed) % 4) + 1;
        memHold = 1'b0;
      end else begin
        memHold = memReqValid;
        heldAddr = memReqAddr;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic doRead(input cacheAddrT addr, output logic missed);
    int memBefore;
    logic expHit;
    logic done;
    logic holding;
    cacheDataT heldData;
    memBefore = memReqCount;
    modelAccess(addr, expHit);
    reqValid = 1'b1;
    reqInvalidate = 1'b0;
    reqAddr = addr;
    while (!reqReady) @(negedge clk);
    @(negedge clk);
    reqValid = 1'b0;
    done = 1'b0;
    holding = 1'b0;
    heldData = '0;
    while (!done) begin
      respReady = (lcgNext(mainSeed) % 4) != 0;
      if (respValid) begin
        if (holding) checkData(respData, heldData, "held respData");
        if (reqReady) begin
          $display("Error at %0t: reqReady is high while a response is pending", $time);
          errorCount++;
        end
        if (respReady) begin
          done = 1'b1;
          checkData(respData, memWord(addr), "respData");
        end
        holding = 1'b1;
        heldData = respData;
      end
      @(negedge clk);
    end
    missed = (memReqCount != memBefore);
    checkMiss(missed, !expHit);
    if (missed) checkAddr(lastMemAddr, addr, "memReqAddr");
    if (memReqCount - memBefore > 1) begin
      $display("Error at %0t: more than one memory request for %h", $time, addr);
      errorCount++;
    end
  endtask

  // No response follows an invalidate, so wait for reqReady to return
  task automatic doInvalidate();
    reqValid = 1'b1;
    reqInvalidate = 1'b1;
    reqAddr = cacheAddrT'(lcgNext(mainSeed));
    while (!reqReady) @(negedge clk);
    @(negedge clk);
    reqValid = 1'b0;
    reqInvalidate = 1'b0;
    modelClear();
    while (!reqReady) begin
      if (respValid) begin
        $display("Error at %0t: a response appeared after an invalidate", $time);
        errorCount++;
      end
      @(negedge clk);
    end
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    testCount++;
    $display("Test %0d %s finished with %0d errors", testCount, name, errorCount - errorsBefore);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int errorsBefore;
    int pick;
    logic missed;
    cacheSetT setSel;
    cacheTagT lruTags [cacheWays];
    cacheTagT evicted;
    cacheTagT tagSel;
    mainSeed = 72;
    memSeed = lcgNext(mainSeed);
    reset = 1'b1;
    reqValid = 1'b0;
    reqAddr = '0;
    reqInvalidate = 1'b0;
    respReady = 1'b0;
    modelClear();
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Filled lines in four sets all miss again after an invalidate
    errorsBefore = errorCount;
    for (int k = 0; k < 4; k++) begin
      lruTags[k] = cacheTagT'(lcgNext(mainSeed));
      doRead({lruTags[k], cacheSetT'(k)}, missed);
    end
    doInvalidate();
    for (int k = 0; k < 4; k++) begin
      doRead({lruTags[k], cacheSetT'(k)}, missed);
      checkMiss(missed, 1'b1);
    end
    finishTest("invalidate", errorsBefore);

    // Fill one set, touch it at random, then force an eviction
    errorsBefore = errorCount;
    setSel = cacheSetT'(lcgNext(mainSeed));
    doInvalidate();
    for (int k = 0; k < cacheWays; k++) begin
      lruTags[k] = cacheTagT'(k * 291 + 17);
      doRead({lruTags[k], setSel}, missed);
      checkMiss(missed, 1'b1);
    end
    for (int k = 0; k < 6; k++) begin
      pick = int'(lcgNext(mainSeed) % 4);
      doRead({lruTags[pick], setSel}, missed);
      checkMiss(missed, 1'b0);
    end
    evicted = modelTag[setSel][modelVictim(setSel)];
    doRead({12'hfff, setSel}, missed);
    checkMiss(missed, 1'b1);
    for (int k = 0; k < cacheWays; k++) begin
      if (lruTags[k] != evicted) begin
        doRead({lruTags[k], setSel}, missed);
        checkMiss(missed, 1'b0);
      end
    end
    doRead({evicted, setSel}, missed);
    checkMiss(missed, 1'b1);
    finishTest("pseudo-LRU replacement", errorsBefore);

    // Few sets and few tags give a mix of hits, misses and evictions
    errorsBefore = errorCount;
    for (int i = 0; i < randomReqs; i++) begin
      if (lcgNext(mainSeed) % 16 == 0) doInvalidate();
      tagSel = cacheTagT'((lcgNext(mainSeed) % 6) * 337);
      setSel = cacheSetT'(lcgNext(mainSeed) % 4);
      doRead({tagSel, setSel}, missed);
    end
    finishTest("random traffic with stalls", errorsBefore);

    $display("Tests run %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog sized from the request count
  initial begin
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/readCache.sv */
/*
  Four-way set-associative read cache with one-word lines.
  Requests are served one at a time, and a miss fetches a single word from memory.
  memRespValid has no ready and is accepted only while a fill is pending.
*/
`timescale 1ns/1ps
`default_nettype none

module readCache (
  input  logic                clk,
  input  logic                reset,
  input  logic                reqValid,
  output logic                reqReady,
  input  cachePkg::cacheAddrT reqAddr,
  input  logic                reqInvalidate,
  output logic                respValid,
  input  logic                respReady,
  output cachePkg::cacheDataT respData,
  output logic                memReqValid,
  input  logic                memReqReady,
  output cachePkg::cacheAddrT memReqAddr,
  input  logic                memRespValid,
  input  cachePkg::cacheDataT memRespData
);
  import cachePkg::*;

  cacheSetT  lookupSet;
  cacheTagT  fillTag;
  cacheDataT fillData;
  wayMaskT   wayWriteEn;
  logic      invalidateAll;
  logic      lruUpdate;
  wayMaskT   accessWay;
  wayMaskT   wayHit;
  wayMaskT   wayValid;
  cacheDataT wayData [cacheWays];
  wayMaskT   hitWay;
  logic      anyHit;
  cacheDataT hitData;
  wayMaskT   victimWay;

  cacheController controller_i (
    .clk, .reset,
    .reqValid, .reqReady, .reqAddr, .reqInvalidate,
    .respValid, .respReady, .respData,
    .memReqValid, .memReqReady, .memReqAddr,
    .memRespValid, .memRespData,
    .anyHit, .hitWay, .hitData, .victimWay,
    .lookupSet, .fillTag, .fillData, .wayWriteEn,
    .invalidateAll, .lruUpdate, .accessWay
  );

  // The registered request tag doubles as the lookup tag
  for (genvar w = 0; w < cacheWays; w++) begin : gWay
    cacheWay way_i (
      .clk, .reset, .lookupSet,
      .lookupTag(fillTag),
      .writeEn(wayWriteEn[w]),
      .fillTag, .fillData, .invalidateAll,
      .hit(wayHit[w]),
      .valid(wayValid[w]),
      .readData(wayData[w])
    );
  end

  wayHitSelect hitSelect_i (.wayHit, .wayData, .hitWay, .anyHit, .hitData);

  cacheLRU lru_i (
    .clk, .reset, .lookupSet,
    .validWay(wayValid),
    .accessWay, .lruUpdate, .invalidateAll, .victimWay
  );

endmodule

`default_nettype wire

/* hw/cacheController.sv */
/*
  Request FSM for the read cache with one request in flight at a time.
  The accepted address is registered so set and tag stay stable through a miss.
  The response word is latched and holds until respReady.
  An invalidate request produces no response.
*/
`timescale 1ns/1ps
`default_nettype none

module cacheController (
  input  logic                clk,
  input  logic                reset,
  input  logic                reqValid,
  output logic                reqReady,
  input  cachePkg::cacheAddrT reqAddr,
  input  logic                reqInvalidate,
  output logic                respValid,
  input  logic                respReady,
  output cachePkg::cacheDataT respData,
  output logic                memReqValid,
  input  logic                memReqReady,
  output cachePkg::cacheAddrT memReqAddr,
  input  logic                memRespValid,
  input  cachePkg::cacheDataT memRespData,
  input  logic                anyHit,
  input  cachePkg::wayMaskT   hitWay,
  input  cachePkg::cacheDataT hitData,
  input  cachePkg::wayMaskT   victimWay,
  output cachePkg::cacheSetT  lookupSet,
  output cachePkg::cacheTagT  fillTag,
  output cachePkg::cacheDataT fillData,
  output cachePkg::wayMaskT   wayWriteEn,
  output logic                invalidateAll,
  output logic                lruUpdate,
  output cachePkg::wayMaskT   accessWay
);
  import cachePkg::*;

  typedef enum logic [2:0] {
    stateIdle,
    stateLookup,
    stateInvalidate,
    stateMemReq,
    stateFillWait,
    stateRespond
  } cacheStateT;

  cacheStateT state;
  cacheStateT nextState;
  cacheAddrT  addrReg;
  cacheDataT  respReg;
  logic       reqFire;
  logic       lookupHit;
  logic       fillNow;

  assign reqReady  = (state == stateIdle);
  assign reqFire   = reqValid && reqReady;
  assign lookupHit = (state == stateLookup) && anyHit;
  assign fillNow   = (state == stateFillWait) && memRespValid;

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      stateIdle:       if (reqFire) nextState = reqInvalidate ? stateInvalidate : stateLookup;
      stateLookup:     nextState = anyHit ? stateRespond : stateMemReq;
      stateInvalidate: nextState = stateIdle;
      stateMemReq:     if (memReqReady) nextState = stateFillWait;
      stateFillWait:   if (memRespValid) nextState = stateRespond;
      stateRespond:    if (respReady) nextState = stateIdle;
      default:         nextState = stateIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stateIdle;
    end else begin
      state <= nextState;
    end
  end

  // Address and response word registers
  always_ff @(posedge clk) begin
    if (reqFire) begin
      addrReg <= reqAddr;
    end
    if (lookupHit) begin
      respReg <= hitData;
    end else if (fillNow) begin
      respReg <= memRespData;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Array and port drive
  ////////////////////////////////////////////////////////////////////////////

  // In idle the arrays read at the incoming address so the hit is known next cycle
  assign lookupSet = (state == stateIdle) ? reqAddr[setBits-1:0] : addrReg[setBits-1:0];
  assign fillTag   = addrReg[addrBits-1 -: tagBits];
  assign fillData  = memRespData;

  // The fill goes to the victim way and refreshes its tree path
  assign wayWriteEn    = fillNow ? victimWay : '0;
  assign invalidateAll = (state == stateInvalidate);
  assign lruUpdate     = lookupHit || fillNow;
  assign accessWay     = (state == stateLookup) ? hitWay : victimWay;

  assign respValid   = (state == stateRespond);
  assign respData    = respReg;
  assign memReqValid = (state == stateMemReq);
  assign memReqAddr  = addrReg;

endmodule

`default_nettype wire

/* hw/wayHitSelect.sv */
/*
  Gathers the per-way hit flags and picks the data of the hitting way.
  Tags in a set are unique, so at most one way hits and an OR of masked words suffices.
  Purely combinational.
*/
`timescale 1ns/1ps
`default_nettype none

module wayHitSelect (
  input  cachePkg::wayMaskT   wayHit,
  input  cachePkg::cacheDataT wayData [cachePkg::cacheWays],
  output cachePkg::wayMaskT   hitWay,
  output logic                anyHit,
  output cachePkg::cacheDataT hitData
);
  import cachePkg::*;

  assign hitWay = wayHit;
  assign anyHit = |wayHit;

  // Each word is masked by its own hit bit before the OR
  always_comb begin
    hitData = '0;
    for (int w = 0; w < cacheWays; w++) begin
      hitData = hitData | (wayData[w] & {dataBits{wayHit[w]}});
    end
  end

endmodule

`default_nettype wire

/* hw/cacheLRU.sv */
/*
  Tree pseudo-LRU for a four-way cache with one set of tree bits per set.
  Tree bits are read one cycle after lookupSet and updates land at the edge.
  An update and a lookup of the same set in one cycle is not forwarded.
  The victim prefers the lowest invalid way over the tree.
*/
`timescale 1ns/1ps
`default_nettype none

module cacheLRU (
  input  logic              clk,
  input  logic              reset,
  input  cachePkg::cacheSetT lookupSet,
  input  cachePkg::wayMaskT validWay,
  input  cachePkg::wayMaskT accessWay,
  input  logic              lruUpdate,
  input  logic              invalidateAll,
  output cachePkg::wayMaskT victimWay
);
  import cachePkg::*;

  // Node 2 is the root and nodes 0 and 1 pick within the low and high pair
  localparam int rootNode = cacheWays - 2;

  lruBitsT  lruMem [cacheSets];
  lruBitsT  currLru;
  lruBitsT  nextLru;
  lruBitsT  wayExpanded;
  lruBitsT  updateEn;
  wayIndexT accessEnc;
  wayIndexT pointedWay;
  wayIndexT firstInvalid;
  wayIndexT victimEnc;
  logic     allValid;

  ////////////////////////////////////////////////////////////////////////////
  // Update path
  ////////////////////////////////////////////////////////////////////////////

  // Encode the one-hot accessWay, which carries a single bit
  always_comb begin
    accessEnc = '0;
    for (int w = 0; w < cacheWays; w++) begin
      if (accessWay[w]) begin
        accessEnc = accessEnc | wayIndexT'(w);
      end
    end
  end

  // The root sees the pair bit and each leaf node sees the low way bit
  assign wayExpanded = {accessEnc[1], {2{accessEnc[0]}}};

  // Only the nodes on the path to the accessed way change
  assign updateEn = {1'b1, accessEnc[1], ~accessEnc[1]};

  // Each node on the path is pointed away from the way just used
  assign nextLru = (updateEn & ~wayExpanded) | (~updateEn & currLru);

  ////////////////////////////////////////////////////////////////////////////
  // Victim selection
  ////////////////////////////////////////////////////////////////////////////

  // Root picks the pair, then that pair's node picks the way
  assign pointedWay = {currLru[rootNode], currLru[currLru[rootNode]]};

  // Scan downward so the lowest invalid way wins
  always_comb begin
    firstInvalid = '0;
    for (int w = cacheWays - 1; w >= 0; w--) begin
      if (!validWay[w]) begin
        firstInvalid = wayIndexT'(w);
      end
    end
  end

  assign allValid  = &validWay;
  assign victimEnc = allValid ? pointedWay : firstInvalid;
  assign victimWay = wayMaskT'(1) << victimEnc;

  ////////////////////////////////////////////////////////////////////////////
  // Tree bit storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || invalidateAll) begin
      for (int s = 0; s < cacheSets; s++) begin
        lruMem[s] <= '0;
      end
    end else if (lruUpdate) begin
      lruMem[lookupSet] <= nextLru;
    end
  end

  // Registered read of the addressed set
  always_ff @(posedge clk) begin
    currLru <= lruMem[lookupSet];
  end

endmodule

`default_nettype wire

/* hw/cacheWay.sv */
/*
  One way of the cache with tag, valid and data arrays.
  Reads are synchronous, so hit and readData are valid one cycle after lookupSet.
  lookupTag is compared against the tag read out, so it must be held for that cycle.
  Writes land at lookupSet on the clock edge.
*/
`timescale 1ns/1ps
`default_nettype none

module cacheWay (
  input  logic                clk,
  input  logic                reset,
  input  cachePkg::cacheSetT  lookupSet,
  input  cachePkg::cacheTagT  lookupTag,
  input  logic                writeEn,
  input  cachePkg::cacheTagT  fillTag,
  input  cachePkg::cacheDataT fillData,
  input  logic                invalidateAll,
  output logic                hit,
  output logic                valid,
  output cachePkg::cacheDataT readData
);
  import cachePkg::*;

  cacheTagT          tagMem  [cacheSets];
  cacheDataT         dataMem [cacheSets];
  logic [cacheSets-1:0] validBits;
  cacheTagT          readTag;

  // Tag and data arrays take the fill word at the looked-up set
  always_ff @(posedge clk) begin
    if (writeEn) begin
      tagMem[lookupSet]  <= fillTag;
      dataMem[lookupSet] <= fillData;
    end
    readTag  <= tagMem[lookupSet];
    readData <= dataMem[lookupSet];
    valid    <= validBits[lookupSet];
  end

  // A fill marks its set valid, and reset or invalidate clears every set
  always_ff @(posedge clk) begin
    if (reset || invalidateAll) begin
      validBits <= '0;
    end else if (writeEn) begin
      validBits[lookupSet] <= 1'b1;
    end
  end

  // Tag compare on the registered read
  assign hit = valid && (readTag == lookupTag);

endmodule

`default_nettype wire

/* hw/cachePkg.sv */
/*
  Geometry and typed widths for the four-way read cache.
  A word address splits into a tag over the high bits and a set index over the low bits.
  Lines hold one word, so there is no offset field.
  setBits plus tagBits must equal addrBits.
*/
`default_nettype none

package cachePkg;

  ////////////////////////////////////////////////////////////////////////////
  // Cache geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int cacheWays = 4;
  localparam int setBits   = 4;
  localparam int cacheSets = 1 << setBits;
  localparam int tagBits   = 12;
  localparam int addrBits  = 16;
  localparam int dataBits  = 32;
  localparam int wayBits   = 2;

  // Widths that carry a meaning in the design
  typedef logic [addrBits-1:0]  cacheAddrT;
  typedef logic [setBits-1:0]   cacheSetT;
  typedef logic [tagBits-1:0]   cacheTagT;
  typedef logic [dataBits-1:0]  cacheDataT;
  typedef logic [cacheWays-1:0] wayMaskT;
  typedef logic [wayBits-1:0]   wayIndexT;
  typedef logic [cacheWays-2:0] lruBitsT;

endpackage

`default_nettype wire
